// ==== fetch_decode.sv ====
// ##############################
// Fetch and decode stage
// Program memory, four-phase issue port, decode report to stacks
// ##############################

`include "simt_defs.svh"

module fetch_decode (
    input  logic                             clk_i,
    input  logic                             arst_n_i,
    // Program memory write port
    input  logic                             imem_we_i,
    input  simt_types_pkg::pc_t              imem_addr_i,
    input  simt_isa_pkg::instr_t             imem_wdata_i,
    // Selection and fetch data
    input  logic                             sel_valid_i,
    input  simt_types_pkg::warp_id_t         sel_warp_i,
    input  simt_types_pkg::pc_t              fetch_pc_i,
    input  simt_types_pkg::act_mask_t        fetch_mask_i,
    output logic                             fetch_busy_o,
    // Issue port to the back end
    output logic                             issue_req_o,
    input  logic                             issue_ack_i,
    output simt_types_pkg::warp_id_t         issue_warp_o,
    output simt_types_pkg::pc_t              issue_pc_o,
    output simt_types_pkg::act_mask_t        issue_mask_o,
    output simt_isa_pkg::instr_t             issue_instr_o,
    // Decode report to the stacks
    output logic [`SIMT_NUM_WARPS-1:0]       decoded_o,
    output logic                             is_branch_o,
    output simt_types_pkg::pc_t              next_pc_or_reconvergence_pc_o,
    output simt_types_pkg::pc_t              branch_target_o,
    output simt_types_pkg::act_mask_t        branch_taken_mask_o
);

    import simt_types_pkg::*;
    import simt_isa_pkg::*;

    typedef enum logic [1:0] {IDLE, REQ, WAIT_ACK_LOW, REPORT} fetch_state_e;

    fetch_state_e state_q;
    fetch_state_e state_d;

    // Program memory
    instr_t imem_q [2**`SIMT_PC_WIDTH];

    // Instruction in flight
    warp_id_t  warp_q;
    pc_t       pc_q;
    act_mask_t mask_q;
    instr_t    instr_q;

    logic    take_sel;
    opcode_e opcode;

    // Accept a new selection only between instructions
    assign take_sel = sel_valid_i && ((state_q == IDLE) || (state_q == REPORT));

    // ##############################
    // Handshake FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:         if (take_sel) state_d = REQ;
            // Drop req once ack is seen
            REQ:          if (issue_ack_i) state_d = WAIT_ACK_LOW;
            WAIT_ACK_LOW: if (!issue_ack_i) state_d = REPORT;
            // Back to back when the next warp is already picked
            REPORT:       state_d = take_sel ? REQ : IDLE;
            default:      state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (imem_we_i) begin
            imem_q[imem_addr_i] <= imem_wdata_i;
        end
    end

    // Latch selection and read memory on the select edge
    always_ff @(posedge clk_i) begin
        if (take_sel) begin
            warp_q  <= sel_warp_i;
            pc_q    <= fetch_pc_i;
            mask_q  <= fetch_mask_i;
            instr_q <= imem_q[fetch_pc_i];
        end
    end

    // ##############################
    // Decode

    assign opcode = instr_opcode(instr_q);

    always_comb begin
        case (opcode)
            OP_JMP:  next_pc_or_reconvergence_pc_o = instr_target(instr_q);
            OP_BRA:  next_pc_or_reconvergence_pc_o = instr_rpc(instr_q);
            // ALU and the unused encoding fall through
            default: next_pc_or_reconvergence_pc_o = pc_q + pc_t'(1);
        endcase
    end

    assign is_branch_o         = (opcode == OP_BRA);
    assign branch_target_o     = instr_target(instr_q);
    assign branch_taken_mask_o = instr_taken_mask(instr_q);

    // Report pulse to the issuing warp only
    always_comb begin
        decoded_o = '0;
        if (state_q == REPORT) begin
            decoded_o[warp_q] = 1'b1;
        end
    end

    assign fetch_busy_o  = (state_q == REQ) || (state_q == WAIT_ACK_LOW);
    assign issue_req_o   = (state_q == REQ);
    assign issue_warp_o  = warp_q;
    assign issue_pc_o    = pc_q;
    assign issue_mask_o  = mask_q;
    assign issue_instr_o = instr_q;

endmodule

// ==== reconvergence_stack.sv ====
// ##############################
// Reconvergence stack for one warp
// Holds PC and active mask, splits on BRA, pops at reconvergence
// ##############################

`include "simt_defs.svh"

module reconvergence_stack (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // Warp load
    input  logic                     init_i,
    input  simt_types_pkg::pc_t      init_pc_i,
    // Scheduler and fetch side
    input  logic                     selected_for_fetch_i,
    output logic                     ready_for_fetch_o,
    output simt_types_pkg::pc_t      fetch_pc_o,
    output simt_types_pkg::act_mask_t fetch_active_mask_o,
    // Decode report
    input  logic                     instruction_decoded_i,
    input  logic                     is_branch_i,
    input  simt_types_pkg::pc_t      next_pc_or_reconvergence_pc_i,
    input  simt_types_pkg::pc_t      branch_target_i,
    input  simt_types_pkg::act_mask_t branch_taken_mask_i
);

    import simt_types_pkg::*;

    // ##############################
    // Stack storage and control

    // Entry fields kept as parallel arrays
    pc_t       entry_pc_q   [`SIMT_STACK_DEPTH];
    act_mask_t entry_mask_q [`SIMT_STACK_DEPTH];
    pc_t       entry_rpc_q  [`SIMT_STACK_DEPTH];

    stack_ptr_t sp_q;
    stack_ptr_t sp_d;
    logic       ready_q;
    logic       ready_d;

    // Top of stack
    pc_t       top_pc;
    act_mask_t top_mask;
    pc_t       top_rpc;

    // Branch split
    act_mask_t  taken_mask;
    act_mask_t  not_taken_mask;
    logic       push_taken;
    logic       push_not_taken;
    stack_ptr_t not_taken_slot;
    stack_ptr_t taken_slot;

    // Leaving this entry at its reconvergence point
    logic       pop;

    assign top_pc   = entry_pc_q[sp_q];
    assign top_mask = entry_mask_q[sp_q];
    assign top_rpc  = entry_rpc_q[sp_q];

    // Only a non-base entry can be popped
    assign pop = (sp_q != '0) && (next_pc_or_reconvergence_pc_i == top_rpc);

    assign taken_mask     = top_mask & branch_taken_mask_i;
    assign not_taken_mask = top_mask & ~branch_taken_mask_i;
    assign push_taken     = |taken_mask;
    assign push_not_taken = |not_taken_mask;

    // Not-taken goes first so the taken path runs first
    assign not_taken_slot = sp_q + stack_ptr_t'(1);
    assign taken_slot     = push_not_taken ? sp_q + stack_ptr_t'(2) : sp_q + stack_ptr_t'(1);

    // ##############################
    // Next control state

    always_comb begin
        sp_d    = sp_q;
        ready_d = ready_q;
        if (init_i) begin
            sp_d    = '0;
            ready_d = 1'b1;
        end else begin
            // Stay out of arbitration while in flight
            if (selected_for_fetch_i) begin
                ready_d = 1'b0;
            end
            if (instruction_decoded_i) begin
                if (is_branch_i) begin
                    sp_d = sp_q + stack_ptr_t'(push_not_taken) + stack_ptr_t'(push_taken);
                end else if (pop) begin
                    sp_d = sp_q - stack_ptr_t'(1);
                end
                ready_d = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sp_q    <= '0;
            ready_q <= 1'b0;
        end else begin
            sp_q    <= sp_d;
            ready_q <= ready_d;
        end
    end

    // Entry contents
    always_ff @(posedge clk_i) begin
        if (init_i) begin
            // Single entry, all threads on
            entry_pc_q[0]   <= init_pc_i;
            entry_mask_q[0] <= '1;
            entry_rpc_q[0]  <= '0;
        end else if (instruction_decoded_i) begin
            if (!is_branch_i) begin
                if (!pop) begin
                    entry_pc_q[sp_q] <= next_pc_or_reconvergence_pc_i;
                end
            end else begin
                // Park current entry at the join point
                entry_pc_q[sp_q] <= next_pc_or_reconvergence_pc_i;
                if (push_not_taken) begin
                    entry_pc_q[not_taken_slot]   <= top_pc + pc_t'(1);
                    entry_mask_q[not_taken_slot] <= not_taken_mask;
                    entry_rpc_q[not_taken_slot]  <= next_pc_or_reconvergence_pc_i;
                end
                if (push_taken) begin
                    entry_pc_q[taken_slot]   <= branch_target_i;
                    entry_mask_q[taken_slot] <= taken_mask;
                    entry_rpc_q[taken_slot]  <= next_pc_or_reconvergence_pc_i;
                end
            end
        end
    end

    assign ready_for_fetch_o   = ready_q;
    assign fetch_pc_o          = top_pc;
    assign fetch_active_mask_o = top_mask;

endmodule

// ==== simt_defs.svh ====
// ##############################
// SIMT front end sizing
// Warp count, warp width, PC, instruction and stack sizes
// ##############################

`ifndef SIMT_DEFS_SVH
`define SIMT_DEFS_SVH

// Warps sharing the front end
`define SIMT_NUM_WARPS 4

// Threads per warp
`define SIMT_WARP_WIDTH 4

// Instruction address width
`define SIMT_PC_WIDTH 8

// Instruction word width
`define SIMT_INSTR_WIDTH 32

// log2 of warp width plus the base entry
`define SIMT_STACK_DEPTH 3

`endif

// ==== simt_frontend_top.sv ====
// ##############################
// SIMT front end top
// Scheduler, fetch stage and one reconvergence stack per warp
// ##############################

`include "simt_defs.svh"

module simt_frontend_top (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    // Warp load
    input  logic                       init_i,
    input  simt_types_pkg::warp_id_t   init_warp_i,
    input  simt_types_pkg::pc_t        init_pc_i,
    // Program memory write port
    input  logic                       imem_we_i,
    input  simt_types_pkg::pc_t        imem_addr_i,
    input  simt_isa_pkg::instr_t       imem_wdata_i,
    // Issue port
    output logic                       issue_req_o,
    input  logic                       issue_ack_i,
    output simt_types_pkg::warp_id_t   issue_warp_o,
    output simt_types_pkg::pc_t        issue_pc_o,
    output simt_types_pkg::act_mask_t  issue_mask_o,
    output simt_isa_pkg::instr_t       issue_instr_o
);

    import simt_types_pkg::*;

    // Per-warp handshakes with the stacks
    logic [`SIMT_NUM_WARPS-1:0] warp_ready;
    logic [`SIMT_NUM_WARPS-1:0] warp_select;
    logic [`SIMT_NUM_WARPS-1:0] warp_decoded;
    pc_t                        stack_pc   [`SIMT_NUM_WARPS];
    act_mask_t                  stack_mask [`SIMT_NUM_WARPS];

    logic      sel_valid;
    warp_id_t  sel_warp;
    logic      fetch_busy;
    pc_t       fetch_pc;
    act_mask_t fetch_mask;

    // Shared decode report
    logic      is_branch;
    pc_t       next_pc;
    pc_t       branch_target;
    act_mask_t branch_taken_mask;

    warp_scheduler i_warp_scheduler (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .warp_ready_i  (warp_ready),
        .fetch_busy_i  (fetch_busy),
        .warp_select_o (warp_select),
        .sel_valid_o   (sel_valid),
        .sel_warp_o    (sel_warp)
    );

    // Selected warp's top entry into fetch
    assign fetch_pc   = stack_pc[sel_warp];
    assign fetch_mask = stack_mask[sel_warp];

    fetch_decode i_fetch_decode (
        .clk_i                         (clk_i),
        .arst_n_i                      (arst_n_i),
        .imem_we_i                     (imem_we_i),
        .imem_addr_i                   (imem_addr_i),
        .imem_wdata_i                  (imem_wdata_i),
        .sel_valid_i                   (sel_valid),
        .sel_warp_i                    (sel_warp),
        .fetch_pc_i                    (fetch_pc),
        .fetch_mask_i                  (fetch_mask),
        .fetch_busy_o                  (fetch_busy),
        .issue_req_o                   (issue_req_o),
        .issue_ack_i                   (issue_ack_i),
        .issue_warp_o                  (issue_warp_o),
        .issue_pc_o                    (issue_pc_o),
        .issue_mask_o                  (issue_mask_o),
        .issue_instr_o                 (issue_instr_o),
        .decoded_o                     (warp_decoded),
        .is_branch_o                   (is_branch),
        .next_pc_or_reconvergence_pc_o (next_pc),
        .branch_target_o               (branch_target),
        .branch_taken_mask_o           (branch_taken_mask)
    );

    // ##############################
    // One stack per warp

    for (genvar w = 0; w < `SIMT_NUM_WARPS; w++) begin : g_stack
        reconvergence_stack i_reconvergence_stack (
            .clk_i                         (clk_i),
            .arst_n_i                      (arst_n_i),
            // Load only the addressed warp
            .init_i                        (init_i && (init_warp_i == warp_id_t'(w))),
            .init_pc_i                     (init_pc_i),
            .selected_for_fetch_i          (warp_select[w]),
            .ready_for_fetch_o             (warp_ready[w]),
            .fetch_pc_o                    (stack_pc[w]),
            .fetch_active_mask_o           (stack_mask[w]),
            .instruction_decoded_i         (warp_decoded[w]),
            .is_branch_i                   (is_branch),
            .next_pc_or_reconvergence_pc_i (next_pc),
            .branch_target_i               (branch_target),
            .branch_taken_mask_i           (branch_taken_mask)
        );
    end

endmodule

// ==== simt_isa_pkg.sv ====
// ##############################
// Instruction set types
// Opcodes, instruction word and field slices
// ##############################

`include "simt_defs.svh"

package simt_isa_pkg;

    import simt_types_pkg::*;

    // Opcodes in bits 31:30, encoding 3 is unused
    typedef enum logic [1:0] {
        OP_ALU = 2'd0,
        OP_JMP = 2'd1,
        OP_BRA = 2'd2
    } opcode_e;

    // Raw instruction word
    typedef logic [`SIMT_INSTR_WIDTH-1:0] instr_t;

    function automatic opcode_e instr_opcode(instr_t instr);
        return opcode_e'(instr[31:30]);
    endfunction

    // Jump or branch target
    function automatic pc_t instr_target(instr_t instr);
        return instr[15:8];
    endfunction

    // Reconvergence point of a divergent branch
    function automatic pc_t instr_rpc(instr_t instr);
        return instr[7:0];
    endfunction

    // Threads that take the branch
    function automatic act_mask_t instr_taken_mask(instr_t instr);
        return instr[27:24];
    endfunction

endpackage

// ==== simt_types_pkg.sv ====
// ##############################
// Machine state types
// PC, thread mask, warp index and stack pointer
// ##############################

`include "simt_defs.svh"

package simt_types_pkg;

    // Instruction address
    typedef logic [`SIMT_PC_WIDTH-1:0] pc_t;

    // One bit per thread, set when active
    typedef logic [`SIMT_WARP_WIDTH-1:0] act_mask_t;

    // Warp index
    typedef logic [$clog2(`SIMT_NUM_WARPS)-1:0] warp_id_t;

    // Index into one warp's reconvergence stack
    typedef logic [$clog2(`SIMT_STACK_DEPTH)-1:0] stack_ptr_t;

endpackage

// ==== sources.f ====
+incdir+.
simt_types_pkg.sv
simt_isa_pkg.sv
reconvergence_stack.sv
warp_scheduler.sv
fetch_decode.sv
simt_frontend_top.sv
tb_simt_model.sv
tb_simt_frontend.sv

// ==== tb_simt_frontend.sv ====
// ##############################
// Testbench for the SIMT front end
// Random programs and ack delays checked against a stack model
// ##############################

`include "simt_defs.svh"

module tb_simt_frontend;
    timeunit 1ns;
    timeprecision 100ps;

    import simt_isa_pkg::*;

    localparam int CLK_PERIOD       = 4;
    localparam int ISSUE_LIMIT      = 400;
    localparam int CYCLES_PER_ISSUE = 20;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        init;
    logic [1:0]  init_warp;
    logic [7:0]  init_pc;
    logic        imem_we;
    logic [7:0]  imem_addr;
    logic [31:0] imem_wdata;
    logic        issue_req;
    logic        issue_ack;
    logic [1:0]  issue_warp;
    logic [7:0]  issue_pc;
    logic [3:0]  issue_mask;
    logic [31:0] issue_instr;

    // Model side
    logic        update;
    logic [1:0]  update_warp;
    logic [31:0] update_instr;
    logic [7:0]  exp_pc;
    logic [3:0]  exp_mask;

    logic [31:0] prog [256];
    int seed = 8;
    int errors = 0;
    int checks = 0;
    int exp_warp = 0;
    int n_jmp = 0;
    int n_bra_part = 0;
    int n_bra_one = 0;

    // Handshake monitor state
    logic        held = 1'b0;
    logic        prev_req = 1'b0;
    logic [45:0] held_data;

    always #(CLK_PERIOD / 2) clk = ~clk;

    simt_frontend_top i_simt_frontend_top (
        .clk_i (clk), .arst_n_i (arst_n),
        .init_i (init), .init_warp_i (init_warp), .init_pc_i (init_pc),
        .imem_we_i (imem_we), .imem_addr_i (imem_addr), .imem_wdata_i (imem_wdata),
        .issue_req_o (issue_req), .issue_ack_i (issue_ack),
        .issue_warp_o (issue_warp), .issue_pc_o (issue_pc),
        .issue_mask_o (issue_mask), .issue_instr_o (issue_instr)
    );

    // Queried by the warp that round robin expects next
    tb_simt_model i_model (
        .clk_i (clk), .init_i (init), .init_warp_i (init_warp), .init_pc_i (init_pc),
        .update_i (update), .update_warp_i (update_warp), .update_instr_i (update_instr),
        .query_warp_i (exp_warp[1:0]), .exp_pc_o (exp_pc), .exp_mask_o (exp_mask)
    );

    function automatic logic [31:0] encode_instr(opcode_e op, logic [3:0] tk,
                                                 logic [7:0] tgt, logic [7:0] rpc);
        return {op, 2'b00, tk, 8'h00, tgt, rpc};
    endfunction

    task automatic compare(string name, logic [31:0] exp_v, logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            $display("FAILED t=%0t %s expected=%h actual=%h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    // One full four-phase issue, ack delay in cycles
    task automatic serve_issue(int delay);
        logic [1:0]  warp;
        logic [3:0]  mask;
        logic [31:0] instr;
        @(negedge clk);
        while (!issue_req) @(negedge clk);
        // Expected issue, captured before the rotation moves on
        warp  = 2'(exp_warp);
        mask  = exp_mask;
        instr = prog[exp_pc];
        compare("issue_warp_o", warp, issue_warp);
        compare("issue_pc_o", exp_pc, issue_pc);
        compare("issue_mask_o", mask, issue_mask);
        compare("issue_instr_o", instr, issue_instr);
        exp_warp = (exp_warp + 1) % `SIMT_NUM_WARPS;
        if (instr[31:30] == 2'd1) begin
            n_jmp++;
        end
        if (instr[31:30] == 2'd2) begin
            if ((instr[27:24] & mask) == 4'h0 || (instr[27:24] & mask) == mask) begin
                n_bra_one++;
            end else begin
                n_bra_part++;
            end
        end
        repeat (delay) @(posedge clk);
        @(posedge clk);
        issue_ack <= 1'b1;
        @(negedge clk);
        while (issue_req) @(negedge clk);
        @(posedge clk);
        issue_ack    <= 1'b0;
        update       <= 1'b1;
        update_warp  <= warp;
        update_instr <= instr;
        @(posedge clk);
        update <= 1'b0;
    endtask

    // Mode 0 zero delay, 1 random 0..5, 2 always 5
    task automatic run_phase(string name, int n, int mode);
        int err0;
        int d;
        err0 = errors;
        for (int i = 0; i < n; i++) begin
            d = (mode == 0) ? 0 : (mode == 2) ? 5 : ($unsigned($random(seed)) % 6);
            serve_issue(d);
        end
        $display("Test %s: %0d issues, %0d errors", name, n, errors - err0);
    endtask

    // Data stable from req rise to ack fall, no req rise under ack
    always @(negedge clk) begin
        if (issue_req && !prev_req && issue_ack) begin
            $display("Handshake error: req rose while ack was high at t=%0t", $time);
            errors++;
        end
        if (held) begin
            if ({issue_warp, issue_pc, issue_mask, issue_instr} !== held_data) begin
                $display("FAILED t=%0t issue data expected=%h actual=%h", $time,
                         held_data, {issue_warp, issue_pc, issue_mask, issue_instr});
                errors++;
            end
            if (!issue_req && !issue_ack) held = 1'b0;
        end else if (issue_req) begin
            held      = 1'b1;
            held_data = {issue_warp, issue_pc, issue_mask, issue_instr};
        end
        prev_req = issue_req;
    end

    initial begin : watchdog
        #(ISSUE_LIMIT * CYCLES_PER_ISSUE * CLK_PERIOD);
        $display("Timeout: the issue port stopped making progress");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        arst_n    = 1'b0;
        init      = 1'b0;
        init_warp = '0;
        init_pc   = '0;
        imem_we   = 1'b0;
        imem_addr = '0;
        imem_wdata = '0;
        issue_ack = 1'b0;
        update    = 1'b0;
        update_warp  = '0;
        update_instr = '0;
        // ALU fill tied to the whole address
        for (int a = 0; a < 256; a++) begin
            prog[a] = {2'b00, 6'h00, 8'($random(seed)), 8'(a), 8'(a) ^ 8'h5A};
        end
        // Partial split, all-taken and none-taken branches
        prog[40]  = encode_instr(OP_BRA, (4'($random(seed)) | 4'h1) & 4'h7, 8'd50, 8'd60);
        prog[150] = encode_instr(OP_BRA, 4'hF, 8'd160, 8'd170);
        prog[200] = encode_instr(OP_BRA, 4'h0, 8'd210, 8'd220);
        prog[100] = encode_instr(OP_JMP, 4'h0, 8'd120 + 8'($unsigned($random(seed)) % 16), 8'h00);
        prog[250] = encode_instr(OP_JMP, 4'h0, 8'($unsigned($random(seed)) % 8), 8'h00);
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        for (int a = 0; a < 256; a++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= 8'(a);
            imem_wdata <= prog[a];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        // Starts placed ahead of the branch and jump sites
        for (int w = 0; w < 4; w++) begin
            @(posedge clk);
            init      <= 1'b1;
            init_warp <= 2'(w);
            init_pc   <= (w == 0) ? 8'd35 : (w == 1) ? 8'd145 : (w == 2) ? 8'd195 : 8'd90;
        end
        @(posedge clk);
        init <= 1'b0;
        run_phase("zero ack delay", 100, 0);
        run_phase("random ack delay", 200, 1);
        run_phase("slow ack delay", 100, 2);
        if (n_jmp == 0 || n_bra_part == 0 || n_bra_one == 0) begin
            $display("Coverage error: a jump or branch kind was never issued");
            errors++;
        end
        $display("Done: %0d checks, %0d errors, %0d JMP, %0d split BRA, %0d single-path BRA",
                 checks, errors, n_jmp, n_bra_part, n_bra_one);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tb_simt_model.sv ====
// ##############################
// Reference model of the warp stacks
// Predicts PC and mask of each warp's next issue
// ##############################

module tb_simt_model (
    input  logic        clk_i,
    input  logic        init_i,
    input  logic [1:0]  init_warp_i,
    input  logic [7:0]  init_pc_i,
    input  logic        update_i,
    input  logic [1:0]  update_warp_i,
    input  logic [31:0] update_instr_i,
    input  logic [1:0]  query_warp_i,
    output logic [7:0]  exp_pc_o,
    output logic [3:0]  exp_mask_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] pc_q   [4][3];
    logic [3:0] mask_q [4][3];
    logic [7:0] rpc_q  [4][3];
    int         sp_q   [4];

    // Top entry of the queried warp
    always_comb begin
        exp_pc_o   = pc_q[query_warp_i][sp_q[query_warp_i]];
        exp_mask_o = mask_q[query_warp_i][sp_q[query_warp_i]];
    end

    always @(posedge clk_i) begin : step
        int         w;
        int         sp;
        logic [7:0] nxt;
        logic [3:0] tk;
        logic [3:0] nt;
        if (init_i) begin
            sp_q[init_warp_i]      = 0;
            pc_q[init_warp_i][0]   = init_pc_i;
            mask_q[init_warp_i][0] = 4'hF;
            rpc_q[init_warp_i][0]  = 8'h00;
        end
        if (update_i) begin
            w  = update_warp_i;
            sp = sp_q[w];
            if (update_instr_i[31:30] == 2'd2) begin
                // Divergent branch, park at the join point and push live paths
                tk = mask_q[w][sp] & update_instr_i[27:24];
                nt = mask_q[w][sp] & ~update_instr_i[27:24];
                nxt = pc_q[w][sp] + 8'd1;
                pc_q[w][sp] = update_instr_i[7:0];
                if (nt != 4'h0) begin
                    sp = sp + 1;
                    pc_q[w][sp]   = nxt;
                    mask_q[w][sp] = nt;
                    rpc_q[w][sp]  = update_instr_i[7:0];
                end
                if (tk != 4'h0) begin
                    sp = sp + 1;
                    pc_q[w][sp]   = update_instr_i[15:8];
                    mask_q[w][sp] = tk;
                    rpc_q[w][sp]  = update_instr_i[7:0];
                end
                sp_q[w] = sp;
            end else begin
                nxt = (update_instr_i[31:30] == 2'd1) ? update_instr_i[15:8]
                                                      : pc_q[w][sp] + 8'd1;
                // Path ends when it reaches its reconvergence PC
                if (sp > 0 && nxt == rpc_q[w][sp]) begin
                    sp_q[w] = sp - 1;
                end else begin
                    pc_q[w][sp] = nxt;
                end
            end
        end
    end

endmodule

// ==== warp_scheduler.sv ====
// ##############################
// Round-robin warp scheduler
// Picks one ready warp while fetch is idle
// ##############################

`include "simt_defs.svh"

module warp_scheduler (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic [`SIMT_NUM_WARPS-1:0]      warp_ready_i,
    input  logic                            fetch_busy_i,
    output logic [`SIMT_NUM_WARPS-1:0]      warp_select_o,
    output logic                            sel_valid_o,
    output simt_types_pkg::warp_id_t        sel_warp_o
);

    import simt_types_pkg::*;

    // Previous winner, search starts just after it
    warp_id_t last_q;

    // ##############################
    // Rotating priority search

    always_comb begin : pick
        int unsigned idx;
        logic        found;
        found      = 1'b0;
        sel_warp_o = last_q;
        for (int i = 1; i <= `SIMT_NUM_WARPS; i++) begin
            idx = (int'(last_q) + i) % `SIMT_NUM_WARPS;
            // First hit after the previous winner
            if (!found && warp_ready_i[idx]) begin
                found      = 1'b1;
                sel_warp_o = warp_id_t'(idx);
            end
        end
        // No grant while an instruction is in flight
        sel_valid_o = found && !fetch_busy_i;
    end

    // One-hot select pulse to the stacks
    always_comb begin
        warp_select_o = '0;
        if (sel_valid_o) begin
            warp_select_o[sel_warp_o] = 1'b1;
        end
    end

    // Last winner register, reset so warp 0 goes first
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_q <= warp_id_t'(`SIMT_NUM_WARPS - 1);
        end else if (sel_valid_o) begin
            last_q <= sel_warp_o;
        end
    end

endmodule
